//--- rtl/dfd_pkg.sv
package dfd_pkg;

  // APB geometry and register map
  localparam int unsigned APB_ADDR_W = 12;
  localparam int unsigned APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] CTRL_OFS   = 12'h000;
  localparam logic [APB_ADDR_W-1:0] STATUS_OFS = 12'h004;
  localparam logic [APB_ADDR_W-1:0] RDPTR_OFS  = 12'h008;
  localparam logic [APB_ADDR_W-1:0] RDDATA_OFS = 12'h00C;

  // Retirement fields, iAddr holds address bits 28:1
  localparam int unsigned IADDR_W  = 28;
  localparam int unsigned ITYPE_W  = 3;
  localparam int unsigned TSTAMP_W = 31;

  typedef struct packed {
    logic [APB_ADDR_W-1:0] addr;
    logic                  sel;
    logic                  enable;
    logic                  write;
    logic [APB_DATA_W-1:0] wdata;
  } apbReq_t;

  typedef struct packed {
    logic                  ready;
    logic [APB_DATA_W-1:0] rdata;
    logic                  slverr;
  } apbRsp_t;

  typedef struct packed {
    logic               valid;
    logic [ITYPE_W-1:0] iType;
    logic [IADDR_W-1:0] iAddr;
  } retire_t;

  typedef struct packed {
    logic               kind;
    logic [ITYPE_W-1:0] iType;
    logic [IADDR_W-1:0] iAddr;
  } instWord_t;

  typedef struct packed {
    logic                kind;
    logic [TSTAMP_W-1:0] tstamp;
  } tsWord_t;

  // Kind bit 31 selects the view
  typedef union packed {
    instWord_t inst;
    tsWord_t   ts;
  } traceWord_u;

  typedef struct packed {
    logic [7:0] period;
    logic       enable;
  } ctrlReg_t;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    TRACING,
    FULL
  } traceState_e;

endpackage

//--- rtl/dfd_apb_regs.sv
`timescale 1ns/1ps

module dfd_apb_regs #(
  parameter int unsigned BUF_DEPTH = 64,
  localparam int unsigned PTR_W = $clog2(BUF_DEPTH),
  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1)
) (
  input  logic                  i_clk,
  input  logic                  i_rstN,
  input  dfd_pkg::apbReq_t      i_apbReq,
  output dfd_pkg::apbRsp_t      o_apbRsp,
  output dfd_pkg::ctrlReg_t     o_ctrl,
  input  dfd_pkg::traceState_e  i_state,
  input  logic [CNT_W-1:0]      i_wrCount,
  output logic [PTR_W-1:0]      o_rdAddr,
  output logic                  o_rdEn,
  input  dfd_pkg::traceWord_u   i_rdData
);

  dfd_pkg::ctrlReg_t                ctrlQ;
  logic [PTR_W-1:0]                 rdPtrQ;
  logic                             rdWaitQ;
  logic                             access;
  logic                             hitCtrl;
  logic                             hitStatus;
  logic                             hitRdPtr;
  logic                             hitRdData;
  logic                             badAccess;
  logic                             rdDataRead;
  logic                             wrAccept;
  logic                             statusFull;
  logic                             statusActive;
  logic [dfd_pkg::APB_DATA_W-1:0]   statusWord;

  assign access    = i_apbReq.sel & i_apbReq.enable;
  assign hitCtrl   = (i_apbReq.addr == dfd_pkg::CTRL_OFS);
  assign hitStatus = (i_apbReq.addr == dfd_pkg::STATUS_OFS);
  assign hitRdPtr  = (i_apbReq.addr == dfd_pkg::RDPTR_OFS);
  assign hitRdData = (i_apbReq.addr == dfd_pkg::RDDATA_OFS);

  // Unmapped offsets and writes to read-only registers
  assign badAccess = ~(hitCtrl | hitStatus | hitRdPtr | hitRdData) |
                     (i_apbReq.write & (hitStatus | hitRdData));

  assign rdDataRead = access & hitRdData & ~i_apbReq.write;
  assign wrAccept   = access & i_apbReq.write & ~badAccess;

  assign statusFull   = (i_wrCount == CNT_W'(BUF_DEPTH));
  assign statusActive = (i_state == dfd_pkg::TRACING);
  assign statusWord   = {16'(i_wrCount), 14'd0, statusFull, statusActive};

  always_comb begin
    o_apbRsp = '0;
    if (access) begin
      // RAM read needs one wait state
      o_apbRsp.ready  = ~rdDataRead | rdWaitQ;
      o_apbRsp.slverr = badAccess;
      if (!badAccess && !i_apbReq.write) begin
        if (hitCtrl) begin
          o_apbRsp.rdata = {16'd0, ctrlQ.period, 7'd0, ctrlQ.enable};
        end else if (hitStatus) begin
          o_apbRsp.rdata = statusWord;
        end else if (hitRdPtr) begin
          o_apbRsp.rdata = dfd_pkg::APB_DATA_W'(rdPtrQ);
        end else if (rdWaitQ) begin
          o_apbRsp.rdata = i_rdData;
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      ctrlQ   <= '0;
      rdPtrQ  <= '0;
      rdWaitQ <= 1'b0;
    end else begin
      rdWaitQ <= rdDataRead & ~rdWaitQ;
      if (wrAccept && hitCtrl) begin
        ctrlQ.period <= i_apbReq.wdata[15:8];
        ctrlQ.enable <= i_apbReq.wdata[0];
      end
      if (wrAccept && hitRdPtr) begin
        rdPtrQ <= i_apbReq.wdata[PTR_W-1:0];
      end else if (rdDataRead && rdWaitQ) begin
        rdPtrQ <= rdPtrQ + PTR_W'(1);
      end
    end
  end

  assign o_ctrl   = ctrlQ;
  assign o_rdEn   = rdDataRead & ~rdWaitQ;
  assign o_rdAddr = rdPtrQ;

endmodule

//--- rtl/dfd_trace_ctrl.sv
`timescale 1ns/1ps

module dfd_trace_ctrl (
  input  logic                  i_clk,
  input  logic                  i_rstN,
  input  dfd_pkg::ctrlReg_t     i_ctrl,
  input  logic                  i_traceStart,
  input  logic                  i_traceStop,
  input  logic                  i_tracePulse,
  input  logic                  i_full,
  output dfd_pkg::traceState_e  o_state,
  output logic                  o_active,
  output logic                  o_start,
  output logic                  o_clear
);

  dfd_pkg::traceState_e stateQ;
  dfd_pkg::traceState_e stateD;
  logic                 startQ;
  logic                 clearQ;

  always_comb begin
    stateD = stateQ;
    if (!i_ctrl.enable) begin
      stateD = dfd_pkg::IDLE;
    end else begin
      case (stateQ)
        dfd_pkg::IDLE: stateD = dfd_pkg::ARMED;
        dfd_pkg::ARMED: begin
          if (i_traceStart || i_tracePulse) stateD = dfd_pkg::TRACING;
        end
        dfd_pkg::TRACING: begin
          if (i_full) begin
            stateD = dfd_pkg::FULL;
          end else if (i_traceStop || i_tracePulse) begin
            stateD = dfd_pkg::ARMED;
          end
        end
        // FULL is left only by clearing enable
        default: stateD = stateQ;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      stateQ <= dfd_pkg::IDLE;
      startQ <= 1'b0;
      clearQ <= 1'b0;
    end else begin
      stateQ <= stateD;
      startQ <= (stateD == dfd_pkg::TRACING) && (stateQ != dfd_pkg::TRACING);
      clearQ <= (stateD == dfd_pkg::IDLE) && (stateQ != dfd_pkg::IDLE);
    end
  end

  assign o_state  = stateQ;
  assign o_active = (stateQ == dfd_pkg::TRACING);
  assign o_start  = startQ;
  assign o_clear  = clearQ;

endmodule

//--- rtl/dfd_trace_timer.sv
`timescale 1ns/1ps

module dfd_trace_timer (
  input  logic                          i_clk,
  input  logic                          i_rstN,
  input  logic                          i_start,
  input  logic [7:0]                    i_period,
  input  logic                          i_instWritten,
  input  logic                          i_tsWritten,
  output logic [dfd_pkg::TSTAMP_W-1:0]  o_tstamp,
  output logic                          o_syncDue
);

  logic [dfd_pkg::TSTAMP_W-1:0] tstampQ;
  logic [7:0]                   syncCntQ;
  logic                         dueQ;
  logic                         periodHit;

  // Instruction written now completes the period
  assign periodHit = (i_period != 8'd0) && i_instWritten && (syncCntQ + 8'd1 == i_period);

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      tstampQ  <= '0;
      syncCntQ <= '0;
      dueQ     <= 1'b0;
    end else begin
      tstampQ <= tstampQ + 1'b1;
      if (i_start) begin
        syncCntQ <= '0;
        dueQ     <= 1'b1;
      end else if (i_tsWritten) begin
        syncCntQ <= '0;
        dueQ     <= 1'b0;
      end else begin
        if (i_instWritten) syncCntQ <= syncCntQ + 8'd1;
        if (periodHit) dueQ <= 1'b1;
      end
    end
  end

  assign o_tstamp  = tstampQ;
  assign o_syncDue = dueQ | i_start | periodHit;

endmodule

//--- rtl/dfd_trace_encoder.sv
`timescale 1ns/1ps

module dfd_trace_encoder (
  input  logic                          i_clk,
  input  logic                          i_rstN,
  input  logic                          i_active,
  input  dfd_pkg::retire_t              i_retire,
  input  logic [dfd_pkg::TSTAMP_W-1:0]  i_tstamp,
  input  logic                          i_syncDue,
  output logic                          o_tsWritten,
  output logic                          o_instWritten,
  output logic                          o_wrEn,
  output dfd_pkg::traceWord_u           o_wrWord,
  output logic                          o_stall
);

  dfd_pkg::traceWord_u instWord;
  dfd_pkg::traceWord_u tsWord;
  dfd_pkg::traceWord_u holdWord;
  dfd_pkg::traceWord_u wrWordQ;
  logic                wrEnQ;
  logic                holdQ;
  logic                accept;

  assign accept = i_active & i_retire.valid & ~holdQ;

  always_comb begin
    instWord.inst.kind  = 1'b0;
    instWord.inst.iType = i_retire.iType;
    instWord.inst.iAddr = i_retire.iAddr;
    tsWord.ts.kind      = 1'b1;
    tsWord.ts.tstamp    = i_tstamp;
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      wrEnQ <= 1'b0;
      holdQ <= 1'b0;
    end else begin
      wrEnQ <= holdQ | accept;
      holdQ <= accept & i_syncDue;
    end
  end

  // Timestamp goes first, instruction waits one cycle
  always_ff @(posedge i_clk) begin
    if (holdQ) begin
      wrWordQ <= holdWord;
    end else if (accept && i_syncDue) begin
      wrWordQ  <= tsWord;
      holdWord <= instWord;
    end else if (accept) begin
      wrWordQ <= instWord;
    end
  end

  assign o_wrEn        = wrEnQ;
  assign o_wrWord      = wrWordQ;
  assign o_tsWritten   = wrEnQ & wrWordQ.ts.kind;
  assign o_instWritten = wrEnQ & ~wrWordQ.inst.kind;
  assign o_stall       = holdQ & i_active;

endmodule

//--- rtl/dfd_trace_buffer.sv
`timescale 1ns/1ps

module dfd_trace_buffer #(
  parameter int unsigned BUF_DEPTH = 64,
  localparam int unsigned PTR_W = $clog2(BUF_DEPTH),
  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1)
) (
  input  logic                 i_clk,
  input  logic                 i_rstN,
  input  logic                 i_clear,
  input  logic                 i_wrEn,
  input  dfd_pkg::traceWord_u  i_wrWord,
  input  logic                 i_rdEn,
  input  logic [PTR_W-1:0]     i_rdAddr,
  output dfd_pkg::traceWord_u  o_rdData,
  output logic [CNT_W-1:0]     o_wrCount,
  output logic                 o_full
);

  dfd_pkg::traceWord_u mem [BUF_DEPTH];
  dfd_pkg::traceWord_u rdDataQ;
  logic [PTR_W-1:0]    wrPtrQ;
  logic [CNT_W-1:0]    wrCountQ;
  logic                doWrite;

  // Writes past the depth are dropped
  assign doWrite = i_wrEn & ~o_full & ~i_clear;

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      wrPtrQ   <= '0;
      wrCountQ <= '0;
    end else if (i_clear) begin
      wrPtrQ   <= '0;
      wrCountQ <= '0;
    end else if (doWrite) begin
      wrPtrQ   <= wrPtrQ + PTR_W'(1);
      wrCountQ <= wrCountQ + CNT_W'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (doWrite) mem[wrPtrQ] <= i_wrWord;
    if (i_rdEn) rdDataQ <= mem[i_rdAddr];
  end

  assign o_rdData  = rdDataQ;
  assign o_wrCount = wrCountQ;
  assign o_full    = (wrCountQ == CNT_W'(BUF_DEPTH));

endmodule

//--- rtl/dfd_trace_top.sv
`timescale 1ns/1ps

module dfd_trace_top #(
  parameter int unsigned BUF_DEPTH = 64
) (
  input  logic              i_clk,
  input  logic              i_rstN,
  input  dfd_pkg::apbReq_t  i_apbReq,
  output dfd_pkg::apbRsp_t  o_apbRsp,
  input  dfd_pkg::retire_t  i_retire,
  input  logic              i_traceStart,
  input  logic              i_traceStop,
  input  logic              i_tracePulse,
  output logic              o_active,
  output logic              o_stall
);

  localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

  dfd_pkg::ctrlReg_t             ctrl;
  dfd_pkg::traceState_e          state;
  logic                          start;
  logic                          clear;
  logic [dfd_pkg::TSTAMP_W-1:0]  tstamp;
  logic                          syncDue;
  logic                          tsWritten;
  logic                          instWritten;
  logic                          wrEn;
  dfd_pkg::traceWord_u           wrWord;
  logic                          rdEn;
  logic [PTR_W-1:0]              rdAddr;
  dfd_pkg::traceWord_u           rdData;
  logic [CNT_W-1:0]              wrCount;
  logic                          full;

  //**************************************************************************
  // Register block and control
  //**************************************************************************
  dfd_apb_regs #(
    .BUF_DEPTH(BUF_DEPTH)
  ) u_regs (
    .i_clk    (i_clk),
    .i_rstN   (i_rstN),
    .i_apbReq (i_apbReq),
    .o_apbRsp (o_apbRsp),
    .o_ctrl   (ctrl),
    .i_state  (state),
    .i_wrCount(wrCount),
    .o_rdAddr (rdAddr),
    .o_rdEn   (rdEn),
    .i_rdData (rdData)
  );

  dfd_trace_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rstN      (i_rstN),
    .i_ctrl      (ctrl),
    .i_traceStart(i_traceStart),
    .i_traceStop (i_traceStop),
    .i_tracePulse(i_tracePulse),
    .i_full      (full),
    .o_state     (state),
    .o_active    (o_active),
    .o_start     (start),
    .o_clear     (clear)
  );

  //**************************************************************************
  // Trace datapath
  //**************************************************************************
  dfd_trace_timer u_timer (
    .i_clk        (i_clk),
    .i_rstN       (i_rstN),
    .i_start      (start),
    .i_period     (ctrl.period),
    .i_instWritten(instWritten),
    .i_tsWritten  (tsWritten),
    .o_tstamp     (tstamp),
    .o_syncDue    (syncDue)
  );

  dfd_trace_encoder u_encoder (
    .i_clk        (i_clk),
    .i_rstN       (i_rstN),
    .i_active     (o_active),
    .i_retire     (i_retire),
    .i_tstamp     (tstamp),
    .i_syncDue    (syncDue),
    .o_tsWritten  (tsWritten),
    .o_instWritten(instWritten),
    .o_wrEn       (wrEn),
    .o_wrWord     (wrWord),
    .o_stall      (o_stall)
  );

  dfd_trace_buffer #(
    .BUF_DEPTH(BUF_DEPTH)
  ) u_buffer (
    .i_clk    (i_clk),
    .i_rstN   (i_rstN),
    .i_clear  (clear),
    .i_wrEn   (wrEn),
    .i_wrWord (wrWord),
    .i_rdEn   (rdEn),
    .i_rdAddr (rdAddr),
    .o_rdData (rdData),
    .o_wrCount(wrCount),
    .o_full   (full)
  );

endmodule

//--- verif/dfd_trace_chk.sv
`timescale 1ns/1ps

module dfd_trace_chk #(
  parameter int unsigned BUF_DEPTH = 64
) (
  input  logic              i_clk,
  input  logic              i_rstN,
  input  dfd_pkg::apbReq_t  i_apbReq,
  input  dfd_pkg::apbRsp_t  i_apbRsp,
  input  dfd_pkg::retire_t  i_retire,
  input  logic              i_active,
  input  logic              i_stall
);

  logic statusRead;

  assign statusRead = i_apbReq.sel & i_apbReq.enable & ~i_apbReq.write & i_apbRsp.ready &
                      (i_apbReq.addr == dfd_pkg::STATUS_OFS);

  errNeedsReady: assert property (@(posedge i_clk) disable iff (!i_rstN)
    i_apbRsp.slverr |-> i_apbRsp.ready)
    else $error("slverr high without ready");

  noRetireInStall: assert property (@(posedge i_clk) disable iff (!i_rstN)
    i_stall |-> !i_retire.valid)
    else $error("retirement presented while stalled");

  stallNeedsActive: assert property (@(posedge i_clk) disable iff (!i_rstN)
    i_stall |-> i_active)
    else $error("stall high while trace inactive");

  countInRange: assert property (@(posedge i_clk) disable iff (!i_rstN)
    statusRead |-> (32'(i_apbRsp.rdata[31:16]) <= BUF_DEPTH))
    else $error("status write count above buffer depth");

endmodule

//--- verif/dfd_trace_scoreboard.sv
`timescale 1ns/1ps

module dfd_trace_scoreboard (
  input  logic              i_clk,
  input  logic              i_rstN,
  input  dfd_pkg::apbReq_t  i_apbReq,
  input  dfd_pkg::apbRsp_t  i_apbRsp,
  input  logic              i_active,
  input  logic              i_stall
);

  logic [31:0]                  expData[$];
  logic [31:0]                  expMask[$];
  logic                         expErr[$];
  logic                         expTs[$];
  string                        expName[$];
  int                           testErrs    = 0;
  int                           totalErrs   = 0;
  int                           testsRun    = 0;
  int                           testsFailed = 0;
  logic                         haveTs      = 1'b0;
  logic [dfd_pkg::TSTAMP_W-1:0] lastTs;

  task automatic reportMismatch(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("FAILED %s: got %h expected %h", sig, got, exp);
    testErrs++;
  endtask

  task automatic noteFailure(input string msg);
    $display("Error: %s", msg);
    testErrs++;
  endtask

  // Queued in the order the transfers will complete
  task automatic expectXfer(input string name, input logic [31:0] data, input logic [31:0] mask,
                            input logic err, input logic ts);
    expName.push_back(name);
    expData.push_back(data);
    expMask.push_back(mask);
    expErr.push_back(err);
    expTs.push_back(ts);
  endtask

  task automatic checkLevels(input logic expActive, input logic expStall);
    if (i_active !== expActive) reportMismatch("o_active", 32'(i_active), 32'(expActive));
    if (i_stall !== expStall) reportMismatch("o_stall", 32'(i_stall), 32'(expStall));
  endtask

  task automatic endTest(input string name);
    if (expErr.size() != 0) begin
      noteFailure($sformatf("%0d APB transfers never completed", expErr.size()));
    end
    testsRun++;
    if (testErrs == 0) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, testErrs);
      testsFailed++;
    end
    totalErrs += testErrs;
    testErrs = 0;
    haveTs   = 1'b0;
    expName.delete();
    expData.delete();
    expMask.delete();
    expErr.delete();
    expTs.delete();
  endtask

  // Compare each completed APB transfer
  always @(posedge i_clk) begin
    dfd_pkg::traceWord_u word;
    string               name;
    logic [31:0]         data;
    logic [31:0]         mask;
    logic                err;
    logic                ts;
    if (i_rstN && i_apbReq.sel && i_apbReq.enable && i_apbRsp.ready) begin
      if (expErr.size() == 0) begin
        noteFailure($sformatf("APB transfer to offset %h was not expected", i_apbReq.addr));
      end else begin
        name = expName.pop_front();
        data = expData.pop_front();
        mask = expMask.pop_front();
        err  = expErr.pop_front();
        ts   = expTs.pop_front();
        word = i_apbRsp.rdata;
        if (i_apbRsp.slverr !== err) begin
          reportMismatch("o_apbRsp.slverr", 32'(i_apbRsp.slverr), 32'(err));
        end else if (ts) begin
          if (word.ts.kind !== 1'b1) begin
            reportMismatch({name, ".kind"}, 32'(word.ts.kind), 32'h1);
          end else if (haveTs && word.ts.tstamp <= lastTs) begin
            $display("FAILED %s.tstamp: got %h expected above %h", name, word.ts.tstamp, lastTs);
            testErrs++;
          end
          lastTs = word.ts.tstamp;
          haveTs = 1'b1;
        end else if ((i_apbRsp.rdata & mask) !== (data & mask)) begin
          reportMismatch(name, i_apbRsp.rdata & mask, data & mask);
        end
      end
    end
  end

endmodule

//--- verif/dfd_trace_tb.sv
`timescale 1ns/1ps

module dfd_trace_tb;

  localparam int unsigned BUF_DEPTH = 64;
  localparam int unsigned MAX_RET   = 30;
  localparam int          CLK_NS    = 8;

  // Cycle budget per test with APB_CYC cycles allowed per APB transfer
  localparam int unsigned APB_CYC     = 5;
  localparam int unsigned RESET_CYC   = 10 + 2 * APB_CYC;
  localparam int unsigned REG_CYC     = 16 * APB_CYC;
  localparam int unsigned CAPTURE_CYC = 4 * MAX_RET + (2 * MAX_RET + 8) * APB_CYC;
  localparam int unsigned GATE_CYC    = 4 * (MAX_RET + 12) + (MAX_RET + 12) * APB_CYC;
  localparam int unsigned FULL_CYC    = 4 * (BUF_DEPTH + 8) + 8 * APB_CYC;
  localparam int unsigned LIMIT_CYC   =
    2 * (RESET_CYC + REG_CYC + CAPTURE_CYC + GATE_CYC + FULL_CYC);

  typedef logic [31:0] wordQ_t[$];

  logic              clk;
  logic              rstN;
  dfd_pkg::apbReq_t  apbReq;
  dfd_pkg::apbRsp_t  apbRsp;
  dfd_pkg::retire_t  retire;
  logic              traceStart;
  logic              traceStop;
  logic              tracePulse;
  logic              active;
  logic              stall;
  wordQ_t            accepted;

  dfd_trace_top #(
    .BUF_DEPTH(BUF_DEPTH)
  ) dut_i (
    .i_clk       (clk),
    .i_rstN      (rstN),
    .i_apbReq    (apbReq),
    .o_apbRsp    (apbRsp),
    .i_retire    (retire),
    .i_traceStart(traceStart),
    .i_traceStop (traceStop),
    .i_tracePulse(tracePulse),
    .o_active    (active),
    .o_stall     (stall)
  );

  dfd_trace_scoreboard sb_i (
    .i_clk   (clk),
    .i_rstN  (rstN),
    .i_apbReq(apbReq),
    .i_apbRsp(apbRsp),
    .i_active(active),
    .i_stall (stall)
  );

  bind dfd_trace_top dfd_trace_chk #(
    .BUF_DEPTH(BUF_DEPTH)
  ) chk_i (
    .i_clk   (i_clk),
    .i_rstN  (i_rstN),
    .i_apbReq(i_apbReq),
    .i_apbRsp(o_apbRsp),
    .i_retire(i_retire),
    .i_active(o_active),
    .i_stall (o_stall)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(CLK_NS * LIMIT_CYC);
    $display("Watchdog: run did not finish within %0d cycles", LIMIT_CYC);
    $display("FAIL: see errors above");
    $finish;
  end

  //**************************************************************************
  // Reference model
  //**************************************************************************
  // Timestamp entries carry only the kind bit
  function automatic wordQ_t expected_trace(input wordQ_t recs, input int unsigned period);
    wordQ_t      words;
    int unsigned sinceTs;
    sinceTs = 0;
    foreach (recs[i]) begin
      if (i == 0 || (period != 0 && sinceTs == period)) begin
        words.push_back(32'h8000_0000);
        sinceTs = 0;
      end
      words.push_back({1'b0, recs[i][30:0]});
      sinceTs++;
    end
    return words;
  endfunction

  function automatic logic [31:0] statusWord(input int unsigned count, input logic full,
                                             input logic act);
    return {16'(count), 14'd0, full, act};
  endfunction

  //**************************************************************************
  // Stimulus
  //**************************************************************************
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
    int unsigned waits;
    int unsigned expWaits;
    // RDDATA reads take one wait state
    expWaits = (!wr && addr == dfd_pkg::RDDATA_OFS) ? 1 : 0;
    apbReq.sel    = 1'b1;
    apbReq.enable = 1'b0;
    apbReq.write  = wr;
    apbReq.addr   = addr;
    apbReq.wdata  = wdata;
    tick();
    apbReq.enable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!apbRsp.ready && waits < 4) begin
      waits++;
      @(negedge clk);
    end
    if (!apbRsp.ready) begin
      sb_i.noteFailure($sformatf("APB ready never rose for offset %h", addr));
    end else if (waits != expWaits) begin
      sb_i.reportMismatch("o_apbRsp.ready wait states", waits, expWaits);
    end
    tick();
    apbReq = '0;
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, input logic err);
    sb_i.expectXfer("pwdata", '0, '0, err, 1'b0);
    apbXfer(1'b1, addr, data);
  endtask

  task automatic apbRead(input string name, input logic [11:0] addr, input logic [31:0] data,
                         input logic err);
    sb_i.expectXfer(name, data, '1, err, 1'b0);
    apbXfer(1'b0, addr, '0);
  endtask

  task automatic readBack(input wordQ_t words);
    apbWrite(dfd_pkg::RDPTR_OFS, '0, 1'b0);
    foreach (words[i]) begin
      sb_i.expectXfer("RDDATA.rdata", words[i], '1, 1'b0, words[i][31]);
      apbXfer(1'b0, dfd_pkg::RDDATA_OFS, '0);
    end
  endtask

  // Presents retirements with random gaps and holds off while stalled
  task automatic driveRetires(input int unsigned count, input logic record);
    int unsigned sent;
    int unsigned gap;
    logic [31:0] rec;
    sent = 0;
    while (sent < count) begin
      retire.valid = 1'b0;
      gap = $urandom_range(0, 2);
      repeat (gap) tick();
      while (stall) tick();
      rec = {1'b0, 3'($urandom_range(0, 7)), 28'($urandom)};
      retire.valid = 1'b1;
      retire.iType = rec[30:28];
      retire.iAddr = rec[27:0];
      if (record) accepted.push_back(rec);
      sent++;
      tick();
    end
    retire.valid = 1'b0;
  endtask

  //**************************************************************************
  // Tests
  //**************************************************************************
  task automatic regTest();
    logic [7:0] period;
    logic       en;
    repeat (4) begin
      period = 8'($urandom_range(0, 255));
      en     = 1'($urandom_range(0, 1));
      apbWrite(dfd_pkg::CTRL_OFS, {16'd0, period, 7'd0, en}, 1'b0);
      apbRead("CTRL.rdata", dfd_pkg::CTRL_OFS, {16'd0, period, 7'd0, en}, 1'b0);
    end
    apbRead("unmapped.rdata", 12'h010, 32'h0, 1'b1);
    apbWrite(dfd_pkg::STATUS_OFS, 32'hFFFF_FFFF, 1'b1);
    apbWrite(dfd_pkg::CTRL_OFS, '0, 1'b0);
    sb_i.endTest("registers");
  endtask

  task automatic captureTest();
    logic [7:0]  period;
    int unsigned count;
    wordQ_t      words;
    period = 8'($urandom_range(0, 5));
    count  = $urandom_range(10, MAX_RET);
    accepted.delete();
    apbWrite(dfd_pkg::CTRL_OFS, {16'd0, period, 7'd0, 1'b1}, 1'b0);
    tick();
    traceStart = 1'b1;
    tick();
    traceStart = 1'b0;
    sb_i.checkLevels(1'b1, 1'b0);
    driveRetires(count, 1'b1);
    repeat (3) tick();
    traceStop = 1'b1;
    tick();
    traceStop = 1'b0;
    sb_i.checkLevels(1'b0, 1'b0);
    words = expected_trace(accepted, 32'(period));
    apbRead("STATUS.rdata", dfd_pkg::STATUS_OFS, statusWord(words.size(), 1'b0, 1'b0), 1'b0);
    readBack(words);
    sb_i.endTest("capture");
  endtask

  task automatic gateTest();
    int unsigned count;
    wordQ_t      words;
    count = $urandom_range(5, 12);
    accepted.delete();
    apbWrite(dfd_pkg::CTRL_OFS, '0, 1'b0);
    apbWrite(dfd_pkg::CTRL_OFS, 32'h1, 1'b0);
    tick();
    sb_i.checkLevels(1'b0, 1'b0);
    driveRetires(6, 1'b0);
    tracePulse = 1'b1;
    tick();
    tracePulse = 1'b0;
    sb_i.checkLevels(1'b1, 1'b0);
    driveRetires(count, 1'b1);
    repeat (3) tick();
    tracePulse = 1'b1;
    tick();
    tracePulse = 1'b0;
    sb_i.checkLevels(1'b0, 1'b0);
    driveRetires(6, 1'b0);
    repeat (3) tick();
    words = expected_trace(accepted, 0);
    apbRead("STATUS.rdata", dfd_pkg::STATUS_OFS, statusWord(words.size(), 1'b0, 1'b0), 1'b0);
    readBack(words);
    sb_i.endTest("gating");
  endtask

  task automatic fullTest();
    int unsigned sent;
    apbWrite(dfd_pkg::CTRL_OFS, '0, 1'b0);
    apbWrite(dfd_pkg::CTRL_OFS, 32'h1, 1'b0);
    tick();
    traceStart = 1'b1;
    tick();
    traceStart = 1'b0;
    sent = 0;
    while (active && sent < BUF_DEPTH + 8) begin
      driveRetires(1, 1'b0);
      sent++;
    end
    repeat (2) tick();
    sb_i.checkLevels(1'b0, 1'b0);
    apbRead("STATUS.rdata", dfd_pkg::STATUS_OFS, statusWord(BUF_DEPTH, 1'b1, 1'b0), 1'b0);
    apbWrite(dfd_pkg::CTRL_OFS, '0, 1'b0);
    tick();
    apbRead("STATUS.rdata", dfd_pkg::STATUS_OFS, 32'h0, 1'b0);
    apbRead("CTRL.rdata", dfd_pkg::CTRL_OFS, 32'h0, 1'b0);
    sb_i.checkLevels(1'b0, 1'b0);
    sb_i.endTest("full");
  endtask

  initial begin
    void'($urandom(32'he9d658b7));
    rstN       = 1'b0;
    apbReq     = '0;
    retire     = '0;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    tick();
    sb_i.checkLevels(1'b0, 1'b0);
    apbRead("STATUS.rdata", dfd_pkg::STATUS_OFS, 32'h0, 1'b0);
    sb_i.endTest("reset");
    regTest();
    captureTest();
    gateTest();
    fullTest();
    $display("%0d tests run, %0d failed, %0d errors",
             sb_i.testsRun, sb_i.testsFailed, sb_i.totalErrs);
    if (sb_i.totalErrs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/dfd_pkg.sv
rtl/dfd_apb_regs.sv
rtl/dfd_trace_ctrl.sv
rtl/dfd_trace_timer.sv
rtl/dfd_trace_encoder.sv
rtl/dfd_trace_buffer.sv
rtl/dfd_trace_top.sv
verif/dfd_trace_chk.sv
verif/dfd_trace_scoreboard.sv
verif/dfd_trace_tb.sv

//--- Makefile
# Verilator build and run of the trace unit testbench
TOP := dfd_trace_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
